//--- tb.f
hdl/axi_pkg.sv
hdl/bridge_ctrl.sv
hdl/read_route.sv
hdl/write_route.sv
hdl/default_slave.sv
hdl/sram_slave.sv
hdl/axi_bridge_top.sv
test/tb_axi_bridge.sv

//--- Bender.yml
package:
  name: axi_bridge

sources:
  - files:
      - hdl/axi_pkg.sv
      - hdl/bridge_ctrl.sv
      - hdl/read_route.sv
      - hdl/write_route.sv
      - hdl/default_slave.sv
      - hdl/sram_slave.sv
      - hdl/axi_bridge_top.sv

  - target: test
    files:
      - test/tb_axi_bridge.sv

//--- test/tb_axi_bridge.sv
`timescale 1ns/10ps

module tb_axi_bridge
	import axi_pkg::*;
();

	localparam int timeout_cycles = 200;

	logic clk;
	logic rst;
	ar_t ar;
	logic ar_valid;
	logic ar_ready;
	r_t r;
	logic r_valid;
	logic r_ready;
	ar_t aw;
	logic aw_valid;
	logic aw_ready;
	w_t w;
	logic w_valid;
	logic w_ready;
	b_t b;
	logic b_valid;
	logic b_ready;

	logic [data_bits-1:0] model [sram_words]; // mirror of the SRAM window
	r_t exp_r[$];
	b_t exp_b[$];
	int r_count = 0;
	int b_count = 0;
	int errors = 0;
	int checks = 0;
	bit stall_on = 1'b0;

	axi_bridge_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// **************************************************
	// reference model
	// **************************************************
	function automatic bit in_window(input logic [addr_bits-1:0] addr);
		return (addr - sram_base) < addr_bits'(sram_words * 4);
	endfunction

	function automatic r_t expect_read(input logic [addr_bits-1:0] addr, input int beat);
		r_t e;
		int word;
		e = '0;
		if (in_window(addr)) begin
			word = (int'((addr - sram_base) >> 2) + beat) % sram_words; // bursts wrap in the window
			e.data = model[word];
			e.resp = resp_okay;
		end else begin
			e.resp = resp_decerr;
		end
		return e;
	endfunction

	function automatic void check_value(input string name, input logic [63:0] got,
			input logic [63:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("Fail %s got %h expected %h", name, got, expected);
		end
	endfunction

	function automatic logic ready_of(input int ch);
		case (ch)
			0: return ar_ready;
			1: return aw_ready;
			default: return w_ready;
		endcase
	endfunction

	// returns on the rising edge where the handshake happens
	task automatic wait_accept(input int ch, input string what, output int cycles);
		bit seen;
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < timeout_cycles) begin
			@(negedge clk);
			seen = ready_of(ch);
			cycles++;
			@(posedge clk);
		end
		if (!seen) begin
			errors++;
			$display("timeout: %s was never accepted", what);
		end
	endtask

	task automatic read_burst(input logic [addr_bits-1:0] addr, input logic [id_bits-1:0] id,
			input int len);
		r_t e;
		int start;
		int cycles;
		int t;
		start = r_count;
		for (int i = 0; i <= len; i++) begin
			e = expect_read(addr, i);
			e.id = id;
			e.last = (i == len);
			exp_r.push_back(e);
		end
		@(posedge clk);
		ar <= '{id: id, addr: addr, len: len_bits'(len), size: 3'd2, burst: burst_incr};
		ar_valid <= 1'b1;
		wait_accept(0, "AR", cycles);
		ar_valid <= 1'b0;
		@(negedge clk);
		if (!r_valid) begin
			errors++;
			$display("first R beat not valid one cycle after the AR transfer");
		end
		t = 0;
		while (r_count < start + len + 1 && t < timeout_cycles) begin
			@(negedge clk);
			t++;
		end
		if (r_count < start + len + 1) begin
			errors++;
			$display("timeout: read burst at %h got %0d of %0d beats", addr, r_count - start,
				len + 1);
		end
	endtask

	task automatic write_burst(input logic [addr_bits-1:0] addr, input logic [id_bits-1:0] id,
			input int len, input bit full_strb);
		b_t eb;
		w_t beat;
		int word;
		int start;
		int cycles;
		int t;
		start = b_count;
		eb.id = id;
		eb.resp = in_window(addr) ? resp_okay : resp_decerr;
		exp_b.push_back(eb);
		@(posedge clk);
		aw <= '{id: id, addr: addr, len: len_bits'(len), size: 3'd2, burst: burst_incr};
		aw_valid <= 1'b1;
		wait_accept(1, "AW", cycles);
		aw_valid <= 1'b0;
		for (int i = 0; i <= len; i++) begin
			beat.data = $urandom;
			beat.strb = full_strb ? '1 : strb_bits'($urandom);
			beat.last = (i == len);
			if (in_window(addr)) begin // unmapped writes leave the model alone
				word = (int'((addr - sram_base) >> 2) + i) % sram_words;
				for (int k = 0; k < strb_bits; k++) begin
					if (beat.strb[k])
						model[word][8*k +: 8] = beat.data[8*k +: 8];
				end
			end
			w <= beat;
			w_valid <= 1'b1;
			wait_accept(2, "W", cycles);
			if (i == 0 && cycles != 1) begin
				errors++;
				$display("w_ready did not rise one cycle after the AW transfer");
			end
		end
		w_valid <= 1'b0;
		@(negedge clk);
		if (!b_valid) begin
			errors++;
			$display("b_valid did not rise one cycle after the last W beat");
		end
		t = 0;
		while (b_count == start && t < timeout_cycles) begin
			@(negedge clk);
			t++;
		end
		if (b_count == start) begin
			errors++;
			$display("timeout: no write response for the burst at %h", addr);
		end
	endtask

	// **************************************************
	// response compare and back-pressure
	// **************************************************
	initial begin : compare_responses
		r_t r_held;
		b_t b_held;
		r_t e;
		b_t eb;
		bit r_stall;
		bit b_stall;
		r_stall = 1'b0;
		b_stall = 1'b0;
		forever begin
			@(negedge clk); // payloads are stable mid cycle
			if (r_stall) begin
				if (!r_valid) begin
					errors++;
					$display("r_valid dropped before the beat was taken");
				end else begin
					check_value("r (held)", r, r_held);
				end
			end
			if (r_valid && r_ready) begin
				r_count++;
				if (exp_r.size() == 0) begin
					errors++;
					$display("unexpected R beat with id %h", r.id);
				end else begin
					e = exp_r.pop_front();
					check_value("r.id", r.id, e.id);
					check_value("r.data", r.data, e.data);
					check_value("r.resp", r.resp, e.resp);
					check_value("r.last", r.last, e.last);
				end
			end
			if (b_stall) begin
				if (!b_valid) begin
					errors++;
					$display("b_valid dropped before the response was taken");
				end else begin
					check_value("b (held)", b, b_held);
				end
			end
			if (b_valid && b_ready) begin
				b_count++;
				if (exp_b.size() == 0) begin
					errors++;
					$display("unexpected write response with id %h", b.id);
				end else begin
					eb = exp_b.pop_front();
					check_value("b.id", b.id, eb.id);
					check_value("b.resp", b.resp, eb.resp);
				end
			end
			r_stall = r_valid && !r_ready;
			b_stall = b_valid && !b_ready;
			r_held = r;
			b_held = b;
		end
	end

	initial begin : drive_ready
		r_ready = 1'b0;
		b_ready = 1'b0;
		forever begin
			@(posedge clk);
			r_ready <= stall_on ? (($urandom % 3) != 0) : 1'b1;
			b_ready <= stall_on ? (($urandom % 3) != 0) : 1'b1;
		end
	end

	// **************************************************
	// test sequence
	// **************************************************
	initial begin : run_tests
		logic [addr_bits-1:0] reg_addr [4];
		int reg_len [4];
		void'($urandom(3735));
		rst <= 1'b0;
		ar <= '0;
		ar_valid <= 1'b0;
		aw <= '0;
		aw_valid <= 1'b0;
		w <= '0;
		w_valid <= 1'b0;
		repeat (3) begin
			@(negedge clk);
			check_value("r_valid", r_valid, 1'b0);
			check_value("b_valid", b_valid, 1'b0);
			check_value("w_ready", w_ready, 1'b0);
		end
		@(posedge clk);
		rst <= 1'b1;
		@(negedge clk);
		check_value("ar_ready", ar_ready, 1'b1);
		check_value("aw_ready", aw_ready, 1'b1);
		check_value("r_valid", r_valid, 1'b0);
		check_value("b_valid", b_valid, 1'b0);
		check_value("w_ready", w_ready, 1'b0);

		// full strobes first so every byte read back is defined
		for (int n = 0; n < 4; n++) begin
			reg_addr[n] = ($urandom % sram_words) * 4;
			reg_len[n] = $urandom % 16;
			write_burst(reg_addr[n], id_bits'($urandom), reg_len[n], 1'b1);
			write_burst(reg_addr[n], id_bits'($urandom), reg_len[n], 1'b0);
			read_burst(reg_addr[n], id_bits'($urandom), reg_len[n]);
		end

		for (int n = 0; n < 3; n++)
			read_burst(32'h0000_1000 + ($urandom & 32'h00ff_fffc), id_bits'($urandom),
				$urandom % 16);
		for (int n = 0; n < 3; n++)
			write_burst(32'h0000_1000 + ($urandom & 32'h00ff_fffc), id_bits'($urandom),
				$urandom % 16, 1'b0);
		read_burst(reg_addr[0], id_bits'($urandom), reg_len[0]);

		stall_on = 1'b1;
		for (int n = 0; n < 3; n++) begin
			write_burst(reg_addr[n + 1], id_bits'($urandom), reg_len[n + 1], 1'b0);
			read_burst(reg_addr[n + 1], id_bits'($urandom), reg_len[n + 1]);
			read_burst(32'h8000_0000 + ($urandom & 32'h0000_fffc), id_bits'($urandom), 15);
			write_burst(32'h8000_0000 + ($urandom & 32'h0000_fffc), id_bits'($urandom), 15, 1'b1);
		end

		// read and write on different slaves at the same time
		fork
			read_burst(32'h0004_0000, id_bits'($urandom), $urandom % 16);
			write_burst(reg_addr[2], id_bits'($urandom), reg_len[2], 1'b0);
		join
		fork
			read_burst(reg_addr[2], id_bits'($urandom), reg_len[2]);
			write_burst(32'h0004_0100, id_bits'($urandom), $urandom % 16, 1'b1);
		join

		repeat (5) @(posedge clk);
		if (exp_r.size() != 0 || exp_b.size() != 0) begin
			errors++;
			$display("expected responses still missing at the end of the run");
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- hdl/axi_bridge_top.sv
`timescale 1ns/10ps

module axi_bridge_top
	import axi_pkg::*;
(
	input logic clk,
	input logic rst,

	input ar_t ar,
	input logic ar_valid,
	output logic ar_ready,
	output r_t r,
	output logic r_valid,
	input logic r_ready,

	input ar_t aw,
	input logic aw_valid,
	output logic aw_ready,
	input w_t w,
	input logic w_valid,
	output logic w_ready,
	output b_t b,
	output logic b_valid,
	input logic b_ready
);

	target_e rd_sel, wr_sel;
	logic rd_open, wr_open;

	ar_t sram_ar, sram_aw, dflt_ar, dflt_aw;
	r_t sram_r, dflt_r;
	w_t sram_w, dflt_w;
	b_t sram_b, dflt_b;
	logic sram_ar_valid, sram_ar_ready, sram_r_valid, sram_r_ready;
	logic sram_aw_valid, sram_aw_ready, sram_w_valid, sram_w_ready;
	logic sram_b_valid, sram_b_ready;
	logic dflt_ar_valid, dflt_ar_ready, dflt_r_valid, dflt_r_ready;
	logic dflt_aw_valid, dflt_aw_ready, dflt_w_valid, dflt_w_ready;
	logic dflt_b_valid, dflt_b_ready;

	bridge_ctrl ctrl_i (
		.clk, .rst,
		.ar_valid, .ar_ready, .ar_addr(ar.addr),
		.r_valid, .r_ready, .r_last(r.last),
		.aw_valid, .aw_ready, .aw_addr(aw.addr),
		.b_valid, .b_ready,
		.rd_sel, .wr_sel, .rd_open, .wr_open
	);

	read_route read_route_i (
		.ar, .ar_valid, .ar_ready, .r, .r_valid, .r_ready,
		.rd_sel, .rd_open,
		.sram_ar, .sram_ar_valid, .sram_ar_ready, .sram_r, .sram_r_valid, .sram_r_ready,
		.dflt_ar, .dflt_ar_valid, .dflt_ar_ready, .dflt_r, .dflt_r_valid, .dflt_r_ready
	);

	write_route write_route_i (
		.aw, .aw_valid, .aw_ready, .w, .w_valid, .w_ready, .b, .b_valid, .b_ready,
		.wr_sel, .wr_open,
		.sram_aw, .sram_aw_valid, .sram_aw_ready, .sram_w, .sram_w_valid, .sram_w_ready,
		.sram_b, .sram_b_valid, .sram_b_ready,
		.dflt_aw, .dflt_aw_valid, .dflt_aw_ready, .dflt_w, .dflt_w_valid, .dflt_w_ready,
		.dflt_b, .dflt_b_valid, .dflt_b_ready
	);

	sram_slave sram_i (
		.clk, .rst,
		.ar(sram_ar), .ar_valid(sram_ar_valid), .ar_ready(sram_ar_ready),
		.r(sram_r), .r_valid(sram_r_valid), .r_ready(sram_r_ready),
		.aw(sram_aw), .aw_valid(sram_aw_valid), .aw_ready(sram_aw_ready),
		.w(sram_w), .w_valid(sram_w_valid), .w_ready(sram_w_ready),
		.b(sram_b), .b_valid(sram_b_valid), .b_ready(sram_b_ready)
	);

	default_slave dflt_i (
		.clk, .rst,
		.ar(dflt_ar), .ar_valid(dflt_ar_valid), .ar_ready(dflt_ar_ready),
		.r(dflt_r), .r_valid(dflt_r_valid), .r_ready(dflt_r_ready),
		.aw(dflt_aw), .aw_valid(dflt_aw_valid), .aw_ready(dflt_aw_ready),
		.w(dflt_w), .w_valid(dflt_w_valid), .w_ready(dflt_w_ready),
		.b(dflt_b), .b_valid(dflt_b_valid), .b_ready(dflt_b_ready)
	);

endmodule

//--- hdl/sram_slave.sv
`timescale 1ns/10ps

module sram_slave
	import axi_pkg::*;
(
	input logic clk,
	input logic rst,

	input ar_t ar,
	input logic ar_valid,
	output logic ar_ready,
	output r_t r,
	output logic r_valid,
	input logic r_ready,

	input ar_t aw,
	input logic aw_valid,
	output logic aw_ready,
	input w_t w,
	input logic w_valid,
	output logic w_ready,
	output b_t b,
	output logic b_valid,
	input logic b_ready
);

	slave_state_e state;
	logic [len_bits-1:0] beats_left;
	logic [id_bits-1:0] id_q;
	logic [sram_addr_bits-1:0] word_addr; // wraps with the window
	logic [data_bits-1:0] mem [sram_words];

	// **************************************************
	// FSM
	// **************************************************
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= st_idle;
			beats_left <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (ar_valid) begin
						state <= st_read;
						beats_left <= ar.len;
					end else if (aw_valid) begin
						state <= st_write;
					end
				end
				st_read: begin
					if (r_ready) begin
						if (beats_left == '0)
							state <= st_idle;
						else
							beats_left <= beats_left - 1'b1;
					end
				end
				st_write: begin
					if (w_valid && w.last)
						state <= st_resp;
				end
				default: begin
					if (b_ready)
						state <= st_idle;
				end
			endcase
		end
	end

	// **************************************************
	// address, ID and memory array
	// **************************************************
	always_ff @(posedge clk) begin
		case (state)
			st_idle: begin
				if (ar_valid) begin
					id_q <= ar.id;
					word_addr <= ar.addr[2 +: sram_addr_bits];
				end else if (aw_valid) begin
					id_q <= aw.id;
					word_addr <= aw.addr[2 +: sram_addr_bits];
				end
			end
			st_read: begin
				if (r_ready)
					word_addr <= word_addr + 1'b1; // every burst type counts up
			end
			st_write: begin
				if (w_valid) begin
					for (int i = 0; i < strb_bits; i++) begin
						if (w.strb[i])
							mem[word_addr][8*i +: 8] <= w.data[8*i +: 8];
					end
					word_addr <= word_addr + 1'b1;
				end
			end
			default: ;
		endcase
	end

	assign ar_ready = (state == st_idle);
	assign aw_ready = (state == st_idle) && !ar_valid;
	assign w_ready = (state == st_write);
	assign r_valid = (state == st_read);
	assign b_valid = (state == st_resp);

	assign r = '{id: id_q, data: mem[word_addr], resp: resp_okay, last: (beats_left == '0)};
	assign b = '{id: id_q, resp: resp_okay};

endmodule

//--- hdl/default_slave.sv
`timescale 1ns/10ps

module default_slave
	import axi_pkg::*;
(
	input logic clk,
	input logic rst,

	input ar_t ar,
	input logic ar_valid,
	output logic ar_ready,
	output r_t r,
	output logic r_valid,
	input logic r_ready,

	input ar_t aw,
	input logic aw_valid,
	output logic aw_ready,
	input w_t w,
	input logic w_valid,
	output logic w_ready,
	output b_t b,
	output logic b_valid,
	input logic b_ready
);

	slave_state_e state;
	logic [len_bits-1:0] beats_left;
	logic [id_bits-1:0] id_q;

	// **************************************************
	// FSM
	// **************************************************
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= st_idle;
			beats_left <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (ar_valid) begin // read wins over write
						state <= st_read;
						beats_left <= ar.len;
					end else if (aw_valid) begin
						state <= st_write;
					end
				end
				st_read: begin
					if (r_ready) begin
						if (beats_left == '0)
							state <= st_idle;
						else
							beats_left <= beats_left - 1'b1;
					end
				end
				st_write: begin
					if (w_valid && w.last)
						state <= st_resp; // data is dropped
				end
				default: begin
					if (b_ready)
						state <= st_idle;
				end
			endcase
		end
	end

	// the ID is registered on the address handshake
	always_ff @(posedge clk) begin
		if (state == st_idle) begin
			if (ar_valid)
				id_q <= ar.id;
			else if (aw_valid)
				id_q <= aw.id;
		end
	end

	assign ar_ready = (state == st_idle);
	assign aw_ready = (state == st_idle) && !ar_valid;
	assign w_ready = (state == st_write);
	assign r_valid = (state == st_read);
	assign b_valid = (state == st_resp);

	assign r = '{id: id_q, data: '0, resp: resp_decerr, last: (beats_left == '0)};
	assign b = '{id: id_q, resp: resp_decerr};

endmodule

//--- hdl/write_route.sv
`timescale 1ns/10ps

module write_route
	import axi_pkg::*;
(
	input ar_t aw,
	input logic aw_valid,
	output logic aw_ready,
	input w_t w,
	input logic w_valid,
	output logic w_ready,
	output b_t b,
	output logic b_valid,
	input logic b_ready,

	input target_e wr_sel,
	input logic wr_open,

	output ar_t sram_aw,
	output logic sram_aw_valid,
	input logic sram_aw_ready,
	output w_t sram_w,
	output logic sram_w_valid,
	input logic sram_w_ready,
	input b_t sram_b,
	input logic sram_b_valid,
	output logic sram_b_ready,

	output ar_t dflt_aw,
	output logic dflt_aw_valid,
	input logic dflt_aw_ready,
	output w_t dflt_w,
	output logic dflt_w_valid,
	input logic dflt_w_ready,
	input b_t dflt_b,
	input logic dflt_b_valid,
	output logic dflt_b_ready
);

	logic to_sram;

	assign to_sram = (wr_sel == tgt_sram);

	// **************************************************
	// AW steering, gated by the open channel
	// **************************************************
	assign sram_aw = aw;
	assign dflt_aw = aw;
	assign sram_aw_valid = aw_valid && wr_open && to_sram;
	assign dflt_aw_valid = aw_valid && wr_open && !to_sram;
	assign aw_ready = wr_open && (to_sram ? sram_aw_ready : dflt_aw_ready);

	// W follows the selection, a slave only raises ready once its AW is taken
	assign sram_w = w;
	assign dflt_w = w;
	assign sram_w_valid = w_valid && to_sram;
	assign dflt_w_valid = w_valid && !to_sram;
	assign w_ready = to_sram ? sram_w_ready : dflt_w_ready;

	// **************************************************
	// B return
	// **************************************************
	assign b = to_sram ? sram_b : dflt_b;
	assign b_valid = !wr_open && (to_sram ? sram_b_valid : dflt_b_valid);
	assign sram_b_ready = b_ready && !wr_open && to_sram;
	assign dflt_b_ready = b_ready && !wr_open && !to_sram;

endmodule

//--- hdl/read_route.sv
`timescale 1ns/10ps

module read_route
	import axi_pkg::*;
(
	input ar_t ar,
	input logic ar_valid,
	output logic ar_ready,
	output r_t r,
	output logic r_valid,
	input logic r_ready,

	input target_e rd_sel,
	input logic rd_open,

	output ar_t sram_ar,
	output logic sram_ar_valid,
	input logic sram_ar_ready,
	input r_t sram_r,
	input logic sram_r_valid,
	output logic sram_r_ready,

	output ar_t dflt_ar,
	output logic dflt_ar_valid,
	input logic dflt_ar_ready,
	input r_t dflt_r,
	input logic dflt_r_valid,
	output logic dflt_r_ready
);

	logic to_sram;

	assign to_sram = (rd_sel == tgt_sram);

	// payload goes to both slaves, only the valid bit is steered
	assign sram_ar = ar;
	assign dflt_ar = ar;
	assign sram_ar_valid = ar_valid && rd_open && to_sram;
	assign dflt_ar_valid = ar_valid && rd_open && !to_sram;
	assign ar_ready = rd_open && (to_sram ? sram_ar_ready : dflt_ar_ready);

	// R only flows while the channel is busy
	assign r = to_sram ? sram_r : dflt_r;
	assign r_valid = !rd_open && (to_sram ? sram_r_valid : dflt_r_valid);
	assign sram_r_ready = r_ready && !rd_open && to_sram;
	assign dflt_r_ready = r_ready && !rd_open && !to_sram;

endmodule

//--- hdl/bridge_ctrl.sv
`timescale 1ns/10ps

module bridge_ctrl
	import axi_pkg::*;
(
	input logic clk,
	input logic rst,

	input logic ar_valid,
	input logic ar_ready,
	input logic [addr_bits-1:0] ar_addr,
	input logic r_valid,
	input logic r_ready,
	input logic r_last,

	input logic aw_valid,
	input logic aw_ready,
	input logic [addr_bits-1:0] aw_addr,
	input logic b_valid,
	input logic b_ready,

	output target_e rd_sel,
	output target_e wr_sel,
	output logic rd_open,
	output logic wr_open
);

	chan_state_e rd_state;
	chan_state_e wr_state;
	target_e rd_tgt;
	target_e wr_tgt;

	// offset against the base so the compare works for any window position
	function automatic target_e decode(input logic [addr_bits-1:0] addr);
		logic [addr_bits-1:0] offset;
		offset = addr - sram_base;
		if (offset < addr_bits'(sram_words * 4))
			return tgt_sram;
		return tgt_default;
	endfunction

	// **************************************************
	// read channel
	// **************************************************
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rd_state <= ch_idle;
			rd_tgt <= tgt_default;
		end else begin
			case (rd_state)
				ch_idle: begin
					if (ar_valid && ar_ready) begin
						rd_state <= ch_busy;
						rd_tgt <= decode(ar_addr); // held until the last R beat
					end
				end
				default: begin
					if (r_valid && r_ready && r_last)
						rd_state <= ch_idle;
				end
			endcase
		end
	end

	// **************************************************
	// write channel
	// **************************************************
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_state <= ch_idle;
			wr_tgt <= tgt_default;
		end else begin
			case (wr_state)
				ch_idle: begin
					if (aw_valid && aw_ready) begin
						wr_state <= ch_busy;
						wr_tgt <= decode(aw_addr);
					end
				end
				default: begin
					if (b_valid && b_ready)
						wr_state <= ch_idle; // B closes the write
				end
			endcase
		end
	end

	assign rd_open = (rd_state == ch_idle);
	assign wr_open = (wr_state == ch_idle);
	assign rd_sel = rd_open ? decode(ar_addr) : rd_tgt; // live decode while idle
	assign wr_sel = wr_open ? decode(aw_addr) : wr_tgt;

endmodule

//--- hdl/axi_pkg.sv
package axi_pkg;

	// **************************************************
	// widths
	// **************************************************
	localparam int id_bits = 4;
	localparam int addr_bits = 32;
	localparam int data_bits = 32;
	localparam int strb_bits = 4;
	localparam int len_bits = 4;
	localparam int size_bits = 3;

	// **************************************************
	// memory map
	// **************************************************
	localparam logic [addr_bits-1:0] sram_base = 32'h0000_0000;
	localparam int sram_words = 1024; // 4 KiB window of 32-bit words
	localparam int sram_addr_bits = $clog2(sram_words);

	typedef enum logic [1:0] {
		resp_okay = 2'b00,
		resp_slverr = 2'b10,
		resp_decerr = 2'b11
	} resp_e;

	typedef enum logic [1:0] {
		burst_fixed = 2'b00,
		burst_incr = 2'b01,
		burst_wrap = 2'b10
	} burst_e;

	typedef enum logic {tgt_sram, tgt_default} target_e;

	typedef enum logic {ch_idle, ch_busy} chan_state_e;

	typedef enum logic [1:0] {st_idle, st_read, st_write, st_resp} slave_state_e;

	// **************************************************
	// channel payloads
	// **************************************************
	typedef struct packed {
		logic [id_bits-1:0] id;
		logic [addr_bits-1:0] addr;
		logic [len_bits-1:0] len; // beats minus one
		logic [size_bits-1:0] size;
		burst_e burst;
	} ar_t; // also carries the AW payload

	typedef struct packed {
		logic [data_bits-1:0] data;
		logic [strb_bits-1:0] strb;
		logic last;
	} w_t;

	typedef struct packed {
		logic [id_bits-1:0] id;
		logic [data_bits-1:0] data;
		resp_e resp;
		logic last;
	} r_t;

	typedef struct packed {
		logic [id_bits-1:0] id;
		resp_e resp;
	} b_t;

endpackage
